// ==== common/flash_pkg.sv ====
// Serial flash reader definitions
`default_nettype none

package flash_pkg;

   // Device geometry. A block holds sixteen pages.
   localparam int FLASH_SIZE = 1048576;
   localparam int PAGE_SIZE  = 256;
   localparam int BLOCK_SIZE = 16 * PAGE_SIZE;

   // Address split into block number and byte offset inside the block.
   localparam int ADDR_W   = $clog2(FLASH_SIZE);
   localparam int OFFSET_W = $clog2(BLOCK_SIZE);
   localparam int BLOCK_W  = ADDR_W - OFFSET_W;

   // System clocks per half SCK period.
   localparam int SCK_DIV = 2;

   // Clocks to wait after the wake command before the next command.
   localparam int RESUME_WAIT = 100;

   typedef enum logic [7:0] {
      CMD_FAST_READ  = 8'h0B,
      CMD_RESUME_DPD = 8'hAB,
      CMD_DPD        = 8'hB9
   } cmd_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WAKE,
      ST_WAKE_WAIT,
      ST_READ_CMD,
      ST_STREAM,
      ST_SLEEP,
      ST_END
   } seq_state_e;

   typedef enum logic [3:0] {
      STATUS_OK  = 4'h0,
      STATUS_END = 4'hF
   } status_e;

endpackage

`default_nettype wire

// ==== spi/spi_byte_engine.sv ====
// SPI byte shift engine
`timescale 1ns/1ps
`default_nettype none

module spi_byte_engine (
   input  wire        clk_i,
   input  wire        rstn_i,
   input  wire        en_i,
   input  wire [7:0]  tx_data_i,
   input  wire        tx_valid_i,
   output logic       tx_ready_o,
   output logic [7:0] rx_data_o,
   output logic       rx_valid_o,
   input  wire        rx_ready_i,
   output logic       sck_o,
   output logic       csn_o,
   output logic       mosi_o,
   input  wire        miso_i
);

   logic                                      busy_q;
   logic [$clog2(flash_pkg::SCK_DIV + 1)-1:0] div_q;
   logic [2:0]                                bit_q;
   logic [7:0]                                tx_shift_q;
   logic [7:0]                                rx_shift_q;
   logic                                      tx_fire;
   logic                                      half_tick;
   logic                                      byte_done;

   // A new byte only starts when the receive holding register is free,
   // so SCK stays parked low while the sequencer is not taking data.
   assign tx_ready_o = ~busy_q & (~rx_valid_o | rx_ready_i);
   assign tx_fire    = tx_valid_i & tx_ready_o;
   assign half_tick  = busy_q & (div_q == flash_pkg::SCK_DIV - 1);
   assign byte_done  = half_tick & sck_o & (bit_q == 3'd7);
   assign mosi_o     = tx_shift_q[7];

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         busy_q     <= 1'b0;
         sck_o      <= 1'b0;
         div_q      <= '0;
         bit_q      <= '0;
         rx_valid_o <= 1'b0;
      end else begin
         if (tx_fire) begin
            busy_q <= 1'b1;
            sck_o  <= 1'b0;
            div_q  <= '0;
            bit_q  <= '0;
         end else if (half_tick) begin
            div_q <= '0;
            sck_o <= ~sck_o;
            // Bits are counted on the falling edge that ends each SCK period.
            if (sck_o) begin
               bit_q <= bit_q + 1'b1;
               if (bit_q == 3'd7) begin
                  busy_q <= 1'b0;
               end
            end
         end else if (busy_q) begin
            div_q <= div_q + 1'b1;
         end
         if (byte_done) begin
            rx_valid_o <= 1'b1;
         end else if (rx_ready_i) begin
            rx_valid_o <= 1'b0;
         end
      end
   end

   // Chip select follows the enable but never rises while a byte is shifting.
   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         csn_o <= 1'b1;
      end else if (tx_fire || en_i) begin
         csn_o <= 1'b0;
      end else if (!busy_q) begin
         csn_o <= 1'b1;
      end
   end

   // In mode 0 mosi changes on the falling edge and miso is sampled on the rising edge.
   always_ff @(posedge clk_i) begin
      if (tx_fire) begin
         tx_shift_q <= tx_data_i;
      end else if (half_tick && sck_o) begin
         tx_shift_q <= {tx_shift_q[6:0], 1'b0};
      end
      if (half_tick && !sck_o) begin
         rx_shift_q <= {rx_shift_q[6:0], miso_i};
      end
      if (byte_done) begin
         rx_data_o <= rx_shift_q;
      end
   end

   a_sck_parked: assert property (@(posedge clk_i) disable iff (!rstn_i)
      csn_o |-> !sck_o);

   a_csn_fall: assert property (@(posedge clk_i) disable iff (!rstn_i)
      $fell(csn_o) |-> (bit_q == 3'd0) && !sck_o);

endmodule

`default_nettype wire

// ==== hw/read_window.sv ====
// Read address window
`timescale 1ns/1ps
`default_nettype none

module read_window (
   input  wire                          clk_i,
   input  wire                          rstn_i,
   input  wire                          in_en_i,
   input  wire                          idle_i,
   input  wire [flash_pkg::BLOCK_W-1:0]  start_block_i,
   input  wire [flash_pkg::BLOCK_W-1:0]  end_block_i,
   input  wire [flash_pkg::OFFSET_W-1:0] read_offset_i,
   input  wire                          byte_taken_i,
   output logic                         start_o,
   output logic [23:0]                  rd_addr_o,
   output logic                         last_o
);

   logic                        en_q;
   logic                        rise;
   logic                        pos_valid_q;
   logic [flash_pkg::ADDR_W-1:0] pos_q;

   // A session only starts on a rising enable seen while the sequencer is idle.
   assign rise = in_en_i & ~en_q & idle_i;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         en_q        <= 1'b0;
         start_o     <= 1'b0;
         pos_valid_q <= 1'b0;
      end else begin
         en_q    <= in_en_i;
         start_o <= rise;
         if (rise) begin
            pos_valid_q <= 1'b1;
         end
      end
   end

   // The position always points at the byte that the application gets next.
   always_ff @(posedge clk_i) begin
      if (rise) begin
         pos_q <= {start_block_i, read_offset_i};
      end else if (byte_taken_i) begin
         pos_q <= pos_q + 1'b1;
      end
   end

   assign rd_addr_o = {{(24 - flash_pkg::ADDR_W){1'b0}}, pos_q};

   // Last byte of the end block, i.e. the offset is all ones.
   assign last_o = pos_valid_q
                 & (pos_q[flash_pkg::ADDR_W-1:flash_pkg::OFFSET_W] == end_block_i)
                 & (&pos_q[flash_pkg::OFFSET_W-1:0]);

   // The sequencer must not hand out data before a session has loaded the position.
   a_taken_after_start: assert property (@(posedge clk_i) disable iff (!rstn_i)
      byte_taken_i |-> pos_valid_q);

endmodule

`default_nettype wire

// ==== hw/flash_seq.sv ====
// Flash read sequencer
`timescale 1ns/1ps
`default_nettype none

module flash_seq (
   input  wire                clk_i,
   input  wire                rstn_i,
   input  wire                start_i,
   input  wire                last_i,
   input  wire [23:0]         rd_addr_i,
   input  wire                in_en_i,
   input  wire                clear_status_i,
   output logic               idle_o,
   output logic               byte_taken_o,
   output logic [7:0]         in_data_o,
   output logic               in_valid_o,
   input  wire                in_ready_i,
   output flash_pkg::status_e status_o,
   output logic               spi_en_o,
   output logic [7:0]         tx_data_o,
   output logic               tx_valid_o,
   input  wire                tx_ready_i,
   input  wire [7:0]          rx_data_i,
   input  wire                rx_valid_i,
   output logic               rx_ready_o
);

   flash_pkg::seq_state_e state_q;
   flash_pkg::seq_state_e state_d;
   logic [2:0]            cnt_q;
   logic [2:0]            cnt_d;
   logic [$clog2(flash_pkg::RESUME_WAIT + 1)-1:0] wait_q;
   logic [$clog2(flash_pkg::RESUME_WAIT + 1)-1:0] wait_d;
   logic                  load;

   assign idle_o       = (state_q == flash_pkg::ST_IDLE);
   assign byte_taken_o = (state_q == flash_pkg::ST_STREAM) & in_valid_o & in_ready_i;
   assign load         = (state_q == flash_pkg::ST_STREAM) & rx_valid_i & rx_ready_o;

   always_comb begin
      if (state_q == flash_pkg::ST_END) begin
         status_o = flash_pkg::STATUS_END;
      end else begin
         status_o = flash_pkg::STATUS_OK;
      end
   end

   always_comb begin
      state_d    = state_q;
      cnt_d      = cnt_q;
      wait_d     = wait_q;
      spi_en_o   = 1'b0;
      tx_valid_o = 1'b0;
      tx_data_o  = 8'h00;
      rx_ready_o = 1'b0;
      case (state_q)
         flash_pkg::ST_IDLE: begin
            cnt_d = '0;
            if (start_i) begin
               state_d = flash_pkg::ST_WAKE;
            end
         end
         flash_pkg::ST_WAKE: begin
            if (cnt_q == 3'd0) begin
               spi_en_o   = 1'b1;
               tx_valid_o = 1'b1;
               tx_data_o  = flash_pkg::CMD_RESUME_DPD;
               if (tx_ready_i) begin
                  cnt_d = 3'd1;
               end
            end else begin
               // Release chip select once the wake byte has left the engine.
               rx_ready_o = 1'b1;
               if (tx_ready_i) begin
                  state_d = flash_pkg::ST_WAKE_WAIT;
                  wait_d  = '0;
               end
            end
         end
         flash_pkg::ST_WAKE_WAIT: begin
            wait_d = wait_q + 1'b1;
            if (wait_q == flash_pkg::RESUME_WAIT) begin
               state_d = flash_pkg::ST_READ_CMD;
               cnt_d   = '0;
            end
         end
         flash_pkg::ST_READ_CMD: begin
            // Opcode, three address bytes and a dummy byte; their rx bytes are dropped.
            spi_en_o   = 1'b1;
            rx_ready_o = 1'b1;
            if (cnt_q < 3'd5) begin
               tx_valid_o = 1'b1;
               if (tx_ready_i) begin
                  cnt_d = cnt_q + 1'b1;
               end
            end else if (rx_valid_i) begin
               state_d = flash_pkg::ST_STREAM;
            end
            case (cnt_q)
               3'd0: tx_data_o = flash_pkg::CMD_FAST_READ;
               3'd1: tx_data_o = rd_addr_i[23:16];
               3'd2: tx_data_o = rd_addr_i[15:8];
               3'd3: tx_data_o = rd_addr_i[7:0];
               default: tx_data_o = 8'h00;
            endcase
         end
         flash_pkg::ST_STREAM: begin
            spi_en_o   = 1'b1;
            tx_valid_o = 1'b1;
            rx_ready_o = ~in_valid_o & in_en_i;
            if (!in_en_i || (byte_taken_o && last_i)) begin
               state_d = flash_pkg::ST_SLEEP;
               cnt_d   = '0;
            end
         end
         flash_pkg::ST_SLEEP: begin
            case (cnt_q)
               3'd0: begin
                  // Drain any byte still in flight and let chip select rise.
                  rx_ready_o = 1'b1;
                  if (tx_ready_i) begin
                     cnt_d = 3'd1;
                  end
               end
               3'd1: begin
                  cnt_d = 3'd2;
               end
               3'd2: begin
                  spi_en_o   = 1'b1;
                  tx_valid_o = 1'b1;
                  tx_data_o  = flash_pkg::CMD_DPD;
                  if (tx_ready_i) begin
                     cnt_d = 3'd3;
                  end
               end
               default: begin
                  rx_ready_o = 1'b1;
                  if (tx_ready_i) begin
                     state_d = flash_pkg::ST_END;
                  end
               end
            endcase
         end
         flash_pkg::ST_END: begin
            if (clear_status_i) begin
               state_d = flash_pkg::ST_IDLE;
            end
         end
         default: begin
            state_d = flash_pkg::ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q    <= flash_pkg::ST_IDLE;
         cnt_q      <= '0;
         wait_q     <= '0;
         in_valid_o <= 1'b0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         wait_q  <= wait_d;
         if (load) begin
            in_valid_o <= 1'b1;
         end else if (byte_taken_o || !in_en_i) begin
            in_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         in_data_o <= rx_data_i;
      end
   end

   // A byte offered to the application stays put until it is accepted.
   a_in_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      in_valid_o && !in_ready_i && in_en_i |=> in_valid_o && $stable(in_data_o));

endmodule

`default_nettype wire

// ==== hw/flash_reader.sv ====
// Serial flash reader top level
`timescale 1ns/1ps
`default_nettype none

module flash_reader (
   input  wire                          clk_i,
   input  wire                          rstn_i,
   input  wire                          in_en_i,
   input  wire [flash_pkg::BLOCK_W-1:0]  start_block_i,
   input  wire [flash_pkg::BLOCK_W-1:0]  end_block_i,
   input  wire [flash_pkg::OFFSET_W-1:0] read_offset_i,
   output logic [7:0]                   in_data_o,
   output logic                         in_valid_o,
   input  wire                          in_ready_i,
   input  wire                          clear_status_i,
   output flash_pkg::status_e           status_o,
   output logic                         sck_o,
   output logic                         csn_o,
   output logic                         mosi_o,
   input  wire                          miso_i
);

   logic        idle;
   logic        start;
   logic        last;
   logic [23:0] rd_addr;
   logic        byte_taken;
   logic        spi_en;
   logic [7:0]  tx_data;
   logic        tx_valid;
   logic        tx_ready;
   logic [7:0]  rx_data;
   logic        rx_valid;
   logic        rx_ready;

   read_window u_window (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .in_en_i       (in_en_i),
      .idle_i        (idle),
      .start_block_i (start_block_i),
      .end_block_i   (end_block_i),
      .read_offset_i (read_offset_i),
      .byte_taken_i  (byte_taken),
      .start_o       (start),
      .rd_addr_o     (rd_addr),
      .last_o        (last)
   );

   flash_seq u_seq (
      .clk_i          (clk_i),
      .rstn_i         (rstn_i),
      .start_i        (start),
      .last_i         (last),
      .rd_addr_i      (rd_addr),
      .in_en_i        (in_en_i),
      .clear_status_i (clear_status_i),
      .idle_o         (idle),
      .byte_taken_o   (byte_taken),
      .in_data_o      (in_data_o),
      .in_valid_o     (in_valid_o),
      .in_ready_i     (in_ready_i),
      .status_o       (status_o),
      .spi_en_o       (spi_en),
      .tx_data_o      (tx_data),
      .tx_valid_o     (tx_valid),
      .tx_ready_i     (tx_ready),
      .rx_data_i      (rx_data),
      .rx_valid_i     (rx_valid),
      .rx_ready_o     (rx_ready)
   );

   spi_byte_engine u_spi (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .en_i       (spi_en),
      .tx_data_i  (tx_data),
      .tx_valid_i (tx_valid),
      .tx_ready_o (tx_ready),
      .rx_data_o  (rx_data),
      .rx_valid_o (rx_valid),
      .rx_ready_i (rx_ready),
      .sck_o      (sck_o),
      .csn_o      (csn_o),
      .mosi_o     (mosi_o),
      .miso_i     (miso_i)
   );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk_o,
   output logic rstn_o
);

   localparam int HALF_PERIOD = 4;

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Reset is held low for three rising edges.
   initial begin
      rstn_o = 1'b0;
      repeat (3) @(posedge clk_o);
      rstn_o <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== verif/flash_model.sv ====
// Behavioral SPI NOR flash
`timescale 1ns/1ps
`default_nettype none

module flash_model (
   input  wire  clk_i,
   input  wire  sck_i,
   input  wire  csn_i,
   input  wire  mosi_i,
   output logic miso_o,
   output logic asleep_o,
   output logic fault_o
);

   int unsigned cycle;
   int unsigned wake_cycle;
   int unsigned frame_cycle;
   int          bit_cnt;
   int          byte_cnt;
   logic [7:0]  in_sr;
   logic [7:0]  out_sr;
   logic [7:0]  opcode;
   logic [23:0] addr;

   // Stored data is the low address byte XOR the block number.
   function automatic logic [7:0] data_at(input logic [23:0] a);
      data_at = a[7:0] ^ a[flash_pkg::ADDR_W-1:flash_pkg::OFFSET_W];
   endfunction

   task automatic report_fault(input string what);
      $display("Flash model fault at %0t ns: %s", $time, what);
      fault_o = 1'b1;
   endtask

   // The part powers up in deep power-down.
   initial begin
      miso_o   = 1'b0;
      asleep_o = 1'b1;
      fault_o  = 1'b0;
      opcode   = 8'h00;
      addr     = '0;
   end

   always @(posedge clk_i) begin
      cycle <= cycle + 1;
   end

   always @(negedge csn_i) begin
      bit_cnt     = 0;
      byte_cnt    = 0;
      opcode      = 8'h00;
      frame_cycle = cycle;
   end

   // Command decode on the eighth rising edge of each byte.
   always @(posedge sck_i) begin
      if (!csn_i) begin
         in_sr   = {in_sr[6:0], mosi_i};
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 8) begin
            bit_cnt = 0;
            if (byte_cnt == 0) begin
               opcode = in_sr;
               if (asleep_o && in_sr != flash_pkg::CMD_RESUME_DPD) begin
                  report_fault("command received while in deep power-down");
               end else begin
                  case (in_sr)
                     flash_pkg::CMD_RESUME_DPD: begin
                        // A wake while awake means the last session skipped power-down.
                        if (!asleep_o) begin
                           report_fault("wake while awake, deep power-down was missing");
                        end
                        asleep_o   = 1'b0;
                        wake_cycle = cycle;
                     end
                     flash_pkg::CMD_DPD: begin
                        asleep_o = 1'b1;
                     end
                     flash_pkg::CMD_FAST_READ: begin
                        if (frame_cycle - wake_cycle < flash_pkg::RESUME_WAIT) begin
                           report_fault("fast read issued before the resume time ran out");
                        end
                     end
                     default: begin
                        report_fault("unknown command opcode");
                     end
                  endcase
               end
            end else if (opcode == flash_pkg::CMD_FAST_READ && byte_cnt <= 3) begin
               addr = {addr[15:0], in_sr};
            end
            byte_cnt = byte_cnt + 1;
         end
      end
   end

   // Mode 0 output: the next bit appears on each falling edge.
   always @(negedge sck_i) begin
      if (!csn_i) begin
         if (bit_cnt == 0) begin
            if (opcode == flash_pkg::CMD_FAST_READ && byte_cnt >= 5) begin
               out_sr = data_at(addr);
               addr   = addr + 1;
            end else begin
               out_sr = 8'h00;
            end
         end
         miso_o = out_sr[7];
         out_sr = {out_sr[6:0], 1'b0};
      end
   end

endmodule

`default_nettype wire

// ==== verif/tb_flash_reader.sv ====
// Flash reader testbench
`timescale 1ns/1ps
`default_nettype none

module tb_flash_reader;

   localparam int CLK_PERIOD = 8;
   localparam int BYTE_CLKS  = 16 * flash_pkg::SCK_DIV;
   // Each session spends a wake byte, five header bytes, two bytes in flight and a DPD byte.
   localparam int SESSIONS    = 5;
   localparam int DATA_BYTES  = 6 + 8 + 20 + 4 + 5;
   localparam int WORST_BYTES = SESSIONS * 9 + DATA_BYTES;
   localparam int WORST_CLKS  = WORST_BYTES * BYTE_CLKS
                              + SESSIONS * (flash_pkg::RESUME_WAIT + 60);
   localparam int TIMEOUT_NS  = 2 * WORST_CLKS * CLK_PERIOD;

   logic                          clk;
   logic                          rstn;
   logic                          in_en;
   logic [flash_pkg::BLOCK_W-1:0]  start_block;
   logic [flash_pkg::BLOCK_W-1:0]  end_block;
   logic [flash_pkg::OFFSET_W-1:0] read_offset;
   logic                          in_ready;
   logic                          clear_status;
   logic [7:0]                    in_data;
   logic                          in_valid;
   flash_pkg::status_e            status;
   logic                          sck;
   logic                          csn;
   logic                          mosi;
   logic                          miso;
   logic                          asleep;
   logic                          model_fault;
   int unsigned                   seed_draw;

   tb_clock u_clock (
      .clk_o  (clk),
      .rstn_o (rstn)
   );

   flash_reader dut0 (
      .clk_i          (clk),
      .rstn_i         (rstn),
      .in_en_i        (in_en),
      .start_block_i  (start_block),
      .end_block_i    (end_block),
      .read_offset_i  (read_offset),
      .in_data_o      (in_data),
      .in_valid_o     (in_valid),
      .in_ready_i     (in_ready),
      .clear_status_i (clear_status),
      .status_o       (status),
      .sck_o          (sck),
      .csn_o          (csn),
      .mosi_o         (mosi),
      .miso_i         (miso)
   );

   flash_model u_flash (
      .clk_i    (clk),
      .sck_i    (sck),
      .csn_i    (csn),
      .mosi_i   (mosi),
      .miso_o   (miso),
      .asleep_o (asleep),
      .fault_o  (model_fault)
   );

   task automatic stop_on_failure();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   // Flash content: low address byte XOR block number.
   function automatic logic [7:0] expected_byte(input logic [23:0] a);
      expected_byte = a[7:0] ^ a[flash_pkg::ADDR_W-1:flash_pkg::OFFSET_W];
   endfunction

   function automatic logic [23:0] byte_addr(input int block, input int offset);
      byte_addr = block * (1 << flash_pkg::OFFSET_W) + offset;
   endfunction

   task automatic open_session(input int sb, input int eb, input int off);
      @(posedge clk);
      start_block <= sb;
      end_block   <= eb;
      read_offset <= off;
      in_en       <= 1'b1;
   endtask

   // Takes n bytes, optionally with a random ready, and checks each one.
   task automatic take_bytes(input int n, input logic [23:0] first, input bit random_ready);
      int          got;
      logic [23:0] a;
      got = 0;
      a   = first;
      while (got < n) begin
         @(posedge clk);
         if (in_valid && in_ready) begin
            check_eq(in_data, expected_byte(a), "stream byte");
            a   = a + 1;
            got = got + 1;
         end
         if (got == n) begin
            in_ready <= 1'b0;
         end else if (random_ready) begin
            in_ready <= $urandom_range(1, 0);
         end else begin
            in_ready <= 1'b1;
         end
      end
   endtask

   // Takes bytes until the end status and checks the count and the quiet bus after it.
   task automatic take_until_end(input logic [23:0] first, input int expect_n);
      int          got;
      logic [23:0] a;
      got = 0;
      a   = first;
      in_ready <= 1'b1;
      while (status !== flash_pkg::STATUS_END) begin
         @(posedge clk);
         if (in_valid && in_ready) begin
            check_eq(in_data, expected_byte(a), "stream byte");
            a   = a + 1;
            got = got + 1;
         end
      end
      check_eq(got, expect_n, "bytes delivered before end status");
      check_eq(asleep, 1'b1, "flash in deep power-down at session end");
      repeat (20) begin
         @(posedge clk);
         check_eq(in_valid, 1'b0, "in_valid after end status");
      end
   endtask

   task automatic close_session();
      @(posedge clk);
      in_en    <= 1'b0;
      in_ready <= 1'b0;
      while (status !== flash_pkg::STATUS_END) begin
         @(posedge clk);
      end
      check_eq(asleep, 1'b1, "flash in deep power-down at session end");
   endtask

   task automatic clear_end_status();
      @(posedge clk);
      clear_status <= 1'b1;
      in_en        <= 1'b0;
      @(posedge clk);
      check_eq(status, flash_pkg::STATUS_END, "status before clear is sampled");
      clear_status <= 1'b0;
      @(posedge clk);
      check_eq(status, flash_pkg::STATUS_OK, "status after clear");
   endtask

   task automatic test_reset_state();
      wait (rstn === 1'b1);
      @(posedge clk);
      check_eq(csn, 1'b1, "csn after reset");
      check_eq(sck, 1'b0, "sck after reset");
      check_eq(in_valid, 1'b0, "in_valid after reset");
      check_eq(status, flash_pkg::STATUS_OK, "status after reset");
   endtask

   task automatic test_end_of_range();
      open_session(3, 3, 4090);
      take_until_end(byte_addr(3, 4090), 6);
      clear_end_status();
   endtask

   task automatic test_block_crossing();
      open_session(5, 6, 4094);
      take_bytes(8, byte_addr(5, 4094), 1'b0);
      close_session();
      clear_end_status();
   endtask

   task automatic test_back_pressure();
      open_session(9, 10, 'h0F0);
      take_bytes(20, byte_addr(9, 'h0F0), 1'b1);
      close_session();
      clear_end_status();
   endtask

   // The second session only works if the first left the flash asleep.
   task automatic test_clear_restart();
      open_session(2, 2, 'h123);
      take_bytes(4, byte_addr(2, 'h123), 1'b0);
      close_session();
      clear_end_status();
      open_session(2, 2, 'h7F0);
      take_bytes(5, byte_addr(2, 'h7F0), 1'b0);
      close_session();
      clear_end_status();
   endtask

   always @(posedge model_fault) begin
      stop_on_failure();
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      stop_on_failure();
   end

   initial begin
      in_en        = 1'b0;
      start_block  = '0;
      end_block    = '0;
      read_offset  = '0;
      in_ready     = 1'b0;
      clear_status = 1'b0;
      seed_draw    = $urandom(32'haec9);
      test_reset_state();
      test_end_of_range();
      test_block_crossing();
      test_back_pressure();
      test_clear_restart();
      if (model_fault === 1'b1) begin
         stop_on_failure();
      end else begin
         $display("sim passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== files.f ====
common/flash_pkg.sv
spi/spi_byte_engine.sv
hw/read_window.sv
hw/flash_seq.sv
hw/flash_reader.sv
verif/tb_clock.sv
verif/flash_model.sv
verif/tb_flash_reader.sv
